// File: project.f
verilog/pwm_pkg.sv
verilog/pwm_apb_regs.sv
verilog/pwm_channel.sv
verilog/pwm_top.sv
test/pwm_checker.sv
test/tb_pwm.sv

// File: run_sim.sh
#!/bin/sh
# build and run the PWM testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log
verilator --binary --timing --assert -f project.f --top-module tb_pwm \
	-Mdir obj_dir -o tb_pwm > build.log 2>&1 \
	|| { echo "build failed, see build.log"; exit 1; }
./obj_dir/tb_pwm > sim.log 2>&1
grep -q "Verification failed" sim.log && { echo "FAIL"; exit 1; }
grep -q "Verification passed" sim.log || { echo "FAIL, no result"; exit 1; }
echo "PASS"

// File: test/pwm_checker.sv
`timescale 1ns/1ps
`default_nettype none

module pwm_checker
	import pwm_pkg::*;
#(
	parameter int NUM_CH = 2
) (
	input  wire               clk_i,
	input  wire               rst_i,
	input  wire  [ADDR_W-1:0] paddr_i,
	input  wire               psel_i,
	input  wire               penable_i,
	input  wire               pwrite_i,
	input  wire  [31:0]       pwdata_i,
	input  wire               pslverr_i,
	input  wire  [NUM_CH-1:0] pwm_i,
	input  wire               check_en_i,
	input  wire  [7:0]        test_i,
	output int                err_cnt_o
);

	logic [MODE_W-1:0] mode   [NUM_CH];
	logic [31:0]       per    [NUM_CH];
	logic [31:0]       t1     [NUM_CH];
	logic [31:0]       t2     [NUM_CH];
	logic [31:0]       stp    [NUM_CH];
	logic [31:0]       cur    [NUM_CH]; // heartbeat high run now expected
	logic              synced [NUM_CH];
	logic              last   [NUM_CH];
	int                skip   [NUM_CH]; // runs still to drop after a write
	int                run_len[NUM_CH];
	int                hi_runs[NUM_CH];
	int                err_cnt;
	logic              en_q;

	assign err_cnt_o = err_cnt;

	// expected run length from the channel rules
	function automatic logic [31:0] ref_len(input logic [MODE_W-1:0] md, input logic lvl,
		input logic [31:0] period, input logic [31:0] thr, input logic [31:0] thr2,
		input logic [31:0] step);
		logic [31:0] len;
		if (lvl)
			len = thr;
		else if (md == MODE_HEART && thr + step > thr2)
			len = period - thr + 32'd1; // extra cycle for the ramp restart
		else
			len = period - thr;
		return len;
	endfunction

	function automatic logic on_ramp(input int c, input int len);
		logic [31:0] v;
		logic        hit;
		hit = 1'b0;
		v   = t1[c];
		while (v <= t2[c] && !hit) begin
			hit = (v == 32'(len));
			if (stp[c] == 0)
				break;
			v = v + stp[c];
		end
		return hit;
	endfunction

	task automatic finish_run(input int c, input logic lvl, input int len);
		logic [31:0] exp;
		if (skip[c] > 0) begin
			skip[c]   = skip[c] - 1;
			synced[c] = 1'b0;
		end else if (check_en_i) begin
			case (mode[c])
				MODE_STD: begin
					exp = ref_len(MODE_STD, lvl, per[c], t1[c], t2[c], stp[c]);
					if (exp != 32'(len)) begin
						$display("MISMATCH t=%0t test %0d pwm_o[%0d] %s run: expected %0d, got %0d",
							$time, test_i, c, lvl ? "high" : "low", exp, len);
						err_cnt++;
					end
					if (lvl)
						hi_runs[c]++;
				end
				MODE_HEART: begin
					if (!synced[c]) begin
						if (lvl) begin
							if (!on_ramp(c, len)) begin
								$display("t=%0t channel %0d heartbeat high run of %0d is not on the ramp",
									$time, c, len);
								err_cnt++;
							end
							cur[c]    = 32'(len);
							synced[c] = 1'b1;
							hi_runs[c]++;
						end
					end else begin
						exp = ref_len(MODE_HEART, lvl, per[c], cur[c], t2[c], stp[c]);
						if (exp != 32'(len)) begin
							$display("MISMATCH t=%0t test %0d pwm_o[%0d] %s run: expected %0d, got %0d",
								$time, test_i, c, lvl ? "high" : "low", exp, len);
							err_cnt++;
						end
						if (lvl)
							hi_runs[c]++;
						else
							cur[c] = (cur[c] + stp[c] > t2[c]) ? t1[c] : cur[c] + stp[c];
					end
				end
				default: begin
					if (lvl) begin
						$display("t=%0t channel %0d went high for %0d cycles while off or held",
							$time, c, len);
						err_cnt++;
					end
				end
			endcase
		end
	endtask

	always @(posedge clk_i) begin : watch
		int          ch;
		logic [11:0] off;
		if (!rst_i) begin
			for (int c = 0; c < NUM_CH; c++) begin
				mode[c]    = MODE_OFF;
				per[c]     = '0;
				t1[c]      = '0;
				t2[c]      = '0;
				stp[c]     = '0;
				cur[c]     = '0;
				synced[c]  = 1'b0;
				last[c]    = 1'b0;
				skip[c]    = 2;
				run_len[c] = 0;
				hi_runs[c] = 0;
			end
			err_cnt = 0;
			en_q    = 1'b0;
		end else begin
			for (int c = 0; c < NUM_CH; c++) begin
				if (pwm_i[c] == last[c]) begin
					run_len[c]++;
				end else begin
					finish_run(c, last[c], run_len[c]);
					last[c]    = pwm_i[c];
					run_len[c] = 1;
				end
				if (check_en_i && !en_q)
					skip[c] = 2;
			end
			en_q = check_en_i;
			// follow config from good writes
			if (psel_i && penable_i && pwrite_i && !pslverr_i) begin
				ch  = int'(paddr_i >> $clog2(CH_STRIDE));
				off = paddr_i & 12'h01F;
				if (ch < NUM_CH) begin
					case (off)
						REG_CTRL:   mode[ch] = pwdata_i[1:0];
						REG_PERIOD: per[ch]  = pwdata_i;
						REG_THR1:   t1[ch]   = pwdata_i;
						REG_THR2:   t2[ch]   = pwdata_i;
						REG_STEP:   stp[ch]  = {20'd0, pwdata_i[11:0]};
						default: ;
					endcase
					skip[ch]   = 2; // partial runs around a write
					synced[ch] = 1'b0;
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: test/tb_pwm.sv
`timescale 1ns/1ps
`default_nettype none

module tb_pwm
	import pwm_pkg::*;
();

	localparam int P_STD = 20;
	// rough cycle budget of all tests plus margin
	localparam int WD_CYCLES = 3 * P_STD * 3 + 3 * P_STD * 8 + 2 * 41 * (3 * 5 + 4) + 41 * 16
		+ 3000;

	logic              clk;
	logic              rst;
	logic [ADDR_W-1:0] paddr;
	logic              psel;
	logic              penable;
	logic              pwrite;
	logic [31:0]       pwdata;
	wire  [31:0]       prdata;
	wire               pready;
	wire               pslverr;
	wire  [1:0]        pwm;
	logic              check_en;
	logic [7:0]        test_num;
	int                chk_errs;
	int                tb_errs;
	int                err_base;
	logic [15:0]       lfsr;

	pwm_top #(.NUM_CH(2)) DUT (
		.clk_i(clk), .rst_i(rst), .paddr_i(paddr), .psel_i(psel), .penable_i(penable),
		.pwrite_i(pwrite), .pwdata_i(pwdata), .prdata_o(prdata), .pready_o(pready),
		.pslverr_o(pslverr), .pwm_o(pwm)
	);

	pwm_checker #(.NUM_CH(2)) chk (
		.clk_i(clk), .rst_i(rst), .paddr_i(paddr), .psel_i(psel), .penable_i(penable),
		.pwrite_i(pwrite), .pwdata_i(pwdata), .pslverr_i(pslverr), .pwm_i(pwm),
		.check_en_i(check_en), .test_i(test_num), .err_cnt_o(chk_errs)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	initial begin
		#(WD_CYCLES * 40);
		$display("watchdog expired at t=%0t, a test never reached its pulse count", $time);
		$display("Verification failed");
		$finish;
	end

	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	task automatic draw(input int n, output logic [31:0] v);
		v = '0;
		repeat (n) begin
			v    = {v[30:0], lfsr[0]}; // one step per bit
			lfsr = lfsr_next(lfsr);
		end
	endtask

	function automatic logic [ADDR_W-1:0] addr_of(input int ch, input logic [ADDR_W-1:0] off);
		return ADDR_W'(ch * 32) | off;
	endfunction

	// starts 2 ns after an edge, ends 2 ns after the edge closing the access
	task automatic apb_xfer(input logic wr, input logic [ADDR_W-1:0] a, input logic [31:0] d,
		output logic [31:0] rd, output logic err);
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = wr;
		paddr   = a;
		pwdata  = d;
		@(posedge clk);
		#2 penable = 1'b1;
		@(posedge clk);
		rd  = prdata;
		err = pslverr;
		if (!pready) begin
			$display("t=%0t pready_o stayed low in an access cycle", $time);
			tb_errs++;
		end
		#2;
		psel    = 1'b0;
		penable = 1'b0;
	endtask

	task automatic apb_write(input logic [ADDR_W-1:0] a, input logic [31:0] d);
		logic [31:0] rd;
		logic        err;
		apb_xfer(1'b1, a, d, rd, err);
		if (err) begin
			$display("t=%0t write to 0x%h got an unexpected error response", $time, a);
			tb_errs++;
		end
	endtask

	task automatic read_check(input logic [ADDR_W-1:0] a, input logic [31:0] exp);
		logic [31:0] rd;
		logic        err;
		apb_xfer(1'b0, a, 32'd0, rd, err);
		if (err || rd !== exp) begin
			$display("MISMATCH t=%0t prdata_o @0x%h: expected %h, got %h (pslverr %b)",
				$time, a, exp, rd, err);
			tb_errs++;
		end
	endtask

	task automatic expect_err(input logic wr, input logic [ADDR_W-1:0] a);
		logic [31:0] rd;
		logic        err;
		apb_xfer(wr, a, 32'hDEAD_BEEF, rd, err);
		if (!err) begin
			$display("MISMATCH t=%0t pslverr_o @0x%h: expected 1, got 0", $time, a);
			tb_errs++;
		end
	endtask

	task automatic program_ch(input int ch, input logic [1:0] md, input logic [31:0] per,
		input logic [31:0] thr1, input logic [31:0] thr2, input logic [31:0] step);
		apb_write(addr_of(ch, REG_CTRL), 32'(MODE_OFF));
		apb_write(addr_of(ch, REG_PERIOD), per);
		apb_write(addr_of(ch, REG_THR1), thr1);
		apb_write(addr_of(ch, REG_THR2), thr2);
		apb_write(addr_of(ch, REG_STEP), step);
		apb_write(addr_of(ch, REG_CTRL), 32'(md));
	endtask

	task automatic wait_runs(input int ch, input int n);
		int target;
		target = chk.hi_runs[ch] + n;
		while (chk.hi_runs[ch] < target) begin
			@(posedge clk);
			#2;
		end
	endtask

	task automatic expect_low(input int ch, input int n);
		repeat (n) begin
			@(posedge clk);
			#2;
			if (pwm[ch]) begin
				$display("MISMATCH t=%0t pwm_o[%0d]: expected 0, got 1", $time, ch);
				tb_errs++;
			end
		end
	endtask

	task automatic end_test(input string name);
		int errs;
		errs = tb_errs + chk_errs - err_base;
		$display("test %0d %s: %s (%0d errors)", test_num, name, errs == 0 ? "ok" : "FAILED", errs);
		err_base = tb_errs + chk_errs;
		test_num = test_num + 8'd1;
	endtask

	task automatic heart_params(input logic [31:0] per, output logic [31:0] thr1,
		output logic [31:0] thr2, output logic [31:0] step, output int nv);
		logic [31:0] r;
		draw(3, r);
		thr1 = r + 32'd1;
		draw(2, r);
		step = r + 32'd1;
		draw(1, r);
		thr2 = thr1 + (r + 32'd2) * step;
		draw(1, r);
		thr2 = thr2 + r; // thr2 + step stays below per
		nv   = int'((thr2 - thr1) / step) + 1;
		if (thr2 + step > per - 32'd1) begin
			$display("t=%0t heartbeat parameters out of range", $time);
			tb_errs++;
		end
	endtask

	initial begin : main
		logic [31:0] v;
		logic [31:0] exp_val [5];
		logic [ADDR_W-1:0] offs [5];
		logic [31:0] ph;
		logic [31:0] h1;
		logic [31:0] h2;
		logic [31:0] hs;
		int          nv;
		int          total;
		rst      = 1'b0;
		paddr    = '0;
		psel     = 1'b0;
		penable  = 1'b0;
		pwrite   = 1'b0;
		pwdata   = '0;
		check_en = 1'b0;
		test_num = 8'd1;
		tb_errs  = 0;
		err_base = 0;
		lfsr     = 16'd4747;
		offs     = '{REG_CTRL, REG_PERIOD, REG_THR1, REG_THR2, REG_STEP};
		repeat (10) @(posedge clk);
		#2 rst = 1'b1;

		for (int ch = 0; ch < 2; ch++) begin
			draw(32, v);
			apb_write(addr_of(ch, REG_CTRL), {v[31:2], 2'b11}); // held, counter frozen
			exp_val[0] = 32'd3;
			for (int r = 1; r < 5; r++) begin
				draw(32, v);
				apb_write(addr_of(ch, offs[r]), v);
				exp_val[r] = (r == 4) ? {20'd0, v[11:0]} : v;
			end
			for (int r = 0; r < 5; r++)
				read_check(addr_of(ch, offs[r]), exp_val[r]);
			apb_write(addr_of(ch, REG_CTRL), 32'd0);
		end
		end_test("register readback");

		apb_write(addr_of(0, REG_PERIOD), 32'h1234);
		apb_write(addr_of(1, REG_PERIOD), 32'h5678);
		expect_err(1'b1, addr_of(2, REG_PERIOD));
		expect_err(1'b1, addr_of(0, 12'h014));
		expect_err(1'b1, addr_of(1, 12'h014));
		expect_err(1'b0, addr_of(2, REG_CTRL));
		expect_err(1'b0, addr_of(0, 12'h014));
		read_check(addr_of(0, REG_PERIOD), 32'h1234);
		read_check(addr_of(1, REG_PERIOD), 32'h5678);
		end_test("address errors");

		check_en = 1'b1;
		expect_low(0, 2 * P_STD);
		expect_low(1, 2 * P_STD);
		program_ch(0, MODE_STD, P_STD, 10, 0, 0);
		wait_runs(0, 2);
		apb_write(addr_of(0, REG_CTRL), 32'(MODE_OFF));
		repeat (2) @(posedge clk);
		expect_low(0, 2 * P_STD);
		end_test("off mode");

		program_ch(0, MODE_STD, P_STD, 1, 0, 0);
		wait_runs(0, 4);
		program_ch(0, MODE_STD, P_STD, P_STD / 2, 0, 0);
		wait_runs(0, 4);
		program_ch(0, MODE_STD, P_STD, P_STD - 1, 0, 0);
		wait_runs(0, 4);
		apb_write(addr_of(0, REG_CTRL), 32'(MODE_OFF));
		end_test("standard mode");

		draw(4, v);
		ph = v + 32'd26;
		heart_params(ph, h1, h2, hs, nv);
		program_ch(1, MODE_HEART, ph, h1, h2, hs);
		wait_runs(1, 3 * nv);
		end_test("heartbeat mode");

		program_ch(0, MODE_STD, P_STD, 7, 0, 0);
		heart_params(ph, h1, h2, hs, nv);
		program_ch(1, MODE_HEART, ph, h1, h2, hs);
		wait_runs(1, nv + 1);
		apb_write(addr_of(0, REG_CTRL), 32'(MODE_STD)); // ch1 keeps being checked
		wait_runs(1, nv + 1);
		wait_runs(0, 3);
		end_test("channel independence");

		total = tb_errs + chk_errs;
		$display("tests run %0d, errors %0d", test_num - 8'd1, total);
		if (total == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: verilog/pwm_apb_regs.sv
`timescale 1ns/1ps
`default_nettype none

module pwm_apb_regs
	import pwm_pkg::*;
#(
	parameter int NUM_CH = 2
) (
	input  wire                       clk_i,
	input  wire                       rst_i,

	input  wire  [ADDR_W-1:0]         paddr_i,
	input  wire                       psel_i,
	input  wire                       penable_i,
	input  wire                       pwrite_i,
	input  wire  [31:0]               pwdata_i,
	output logic [31:0]               prdata_o,
	output logic                      pready_o,
	output logic                      pslverr_o,

	output logic [NUM_CH*MODE_W-1:0]  mode_o,
	output logic [NUM_CH*CNT_W-1:0]   period_o,
	output logic [NUM_CH*CNT_W-1:0]   thr1_o,
	output logic [NUM_CH*CNT_W-1:0]   thr2_o,
	output logic [NUM_CH*STEP_W-1:0]  step_o
);

	localparam int unsigned BLK_W = $clog2(CH_STRIDE);

	logic [MODE_W-1:0] mode_r   [NUM_CH];
	logic [CNT_W-1:0]  period_r [NUM_CH];
	logic [CNT_W-1:0]  thr1_r   [NUM_CH];
	logic [CNT_W-1:0]  thr2_r   [NUM_CH];
	logic [STEP_W-1:0] step_r   [NUM_CH];

	logic [ADDR_W-1:0] ch_idx;
	logic [ADDR_W-1:0] offset_w;
	logic              ch_hit;
	logic              off_hit;
	logic              access;
	logic              addr_err;
	logic              wr_en;
	logic [31:0]       rd_val;

	assign ch_idx   = paddr_i >> BLK_W;
	assign offset_w = paddr_i & ADDR_W'(CH_STRIDE - 1);
	assign ch_hit   = (ch_idx < ADDR_W'(NUM_CH));

	always_comb begin
		case (offset_w)
			REG_CTRL, REG_PERIOD, REG_THR1, REG_THR2, REG_STEP: off_hit = 1'b1;
			default: off_hit = 1'b0; // hole or unaligned
		endcase
	end

	assign access   = psel_i && penable_i;
	assign addr_err = !(ch_hit && off_hit);
	assign wr_en    = access && pwrite_i && !addr_err;

	// zero wait states
	assign pready_o  = access;
	assign pslverr_o = access && addr_err;

	always_ff @(posedge clk_i) begin
		if (!rst_i) begin
			for (int i = 0; i < NUM_CH; i++) begin
				mode_r[i]   <= MODE_OFF;
				period_r[i] <= '0;
				thr1_r[i]   <= '0;
				thr2_r[i]   <= '0;
				step_r[i]   <= '0;
			end
		end else if (wr_en) begin
			for (int i = 0; i < NUM_CH; i++) begin
				if (ch_idx == ADDR_W'(i)) begin
					case (offset_w)
						REG_CTRL:   mode_r[i]   <= pwdata_i[MODE_W-1:0];
						REG_PERIOD: period_r[i] <= pwdata_i[CNT_W-1:0];
						REG_THR1:   thr1_r[i]   <= pwdata_i[CNT_W-1:0];
						REG_THR2:   thr2_r[i]   <= pwdata_i[CNT_W-1:0];
						REG_STEP:   step_r[i]   <= pwdata_i[STEP_W-1:0];
						default: ;
					endcase
				end
			end
		end
	end

	// readback, unused bits zero
	always_comb begin
		rd_val = '0;
		for (int i = 0; i < NUM_CH; i++) begin
			if (ch_idx == ADDR_W'(i)) begin
				case (offset_w)
					REG_CTRL:   rd_val = 32'(mode_r[i]);
					REG_PERIOD: rd_val = 32'(period_r[i]);
					REG_THR1:   rd_val = 32'(thr1_r[i]);
					REG_THR2:   rd_val = 32'(thr2_r[i]);
					REG_STEP:   rd_val = 32'(step_r[i]);
					default:    rd_val = '0;
				endcase
			end
		end
	end

	assign prdata_o = access ? rd_val : '0; // quiet outside access phase

	for (genvar i = 0; i < NUM_CH; i++) begin : g_flat
		assign mode_o[i*MODE_W +: MODE_W]   = mode_r[i];
		assign period_o[i*CNT_W +: CNT_W]   = period_r[i];
		assign thr1_o[i*CNT_W +: CNT_W]     = thr1_r[i];
		assign thr2_o[i*CNT_W +: CNT_W]     = thr2_r[i];
		assign step_o[i*STEP_W +: STEP_W]   = step_r[i];
	end

	// access phase must follow a setup phase
	a_setup_before_access: assert property (
		@(posedge clk_i) disable iff (!rst_i)
		$rose(penable_i) |-> psel_i && $past(psel_i && !penable_i)
	) else $error("penable rose without a setup phase");

	// erroring write leaves every channel alone
	a_err_write_ignored: assert property (
		@(posedge clk_i) disable iff (!rst_i)
		pslverr_o && pwrite_i |=> $stable(mode_o) && $stable(period_o) && $stable(thr1_o)
			&& $stable(thr2_o) && $stable(step_o)
	) else $error("erroring write changed a register");

endmodule

`default_nettype wire

// File: verilog/pwm_channel.sv
`timescale 1ns/1ps
`default_nettype none

module pwm_channel
	import pwm_pkg::*;
(
	input  wire                clk_i,
	input  wire                rst_i,

	input  wire  [MODE_W-1:0]  mode_i,
	input  wire  [CNT_W-1:0]   period_i,
	input  wire  [CNT_W-1:0]   thr1_i,
	input  wire  [CNT_W-1:0]   thr2_i,
	input  wire  [STEP_W-1:0]  step_i,

	output logic               pwm_o
);

	logic [CNT_W-1:0] cnt_q;
	logic [CNT_W-1:0] cnt_d;
	logic [CNT_W-1:0] thr_q; // current heartbeat threshold
	logic [CNT_W-1:0] thr_d;
	logic             arm_q; // reload thr1 on heartbeat entry
	logic             arm_d;
	logic             pwm_d;
	logic             wrap;
	logic [CNT_W-1:0] step_ext;

	assign wrap     = (cnt_q == period_i - CNT_W'(1));
	assign step_ext = CNT_W'(step_i);

	always_comb begin
		cnt_d = cnt_q;
		thr_d = thr_q;
		arm_d = arm_q;
		pwm_d = 1'b0;

		case (mode_i)
			MODE_OFF: begin
				arm_d = 1'b1;
			end

			MODE_STD: begin
				arm_d = 1'b1;
				if (wrap) begin
					cnt_d = '0;
				end else begin
					cnt_d = cnt_q + CNT_W'(1);
					pwm_d = (cnt_q < thr1_i);
				end
			end

			MODE_HEART: begin
				if (arm_q) begin
					thr_d = thr1_i; // first entry
					arm_d = 1'b0;
				end else if (thr_q > thr2_i) begin
					cnt_d = '0; // ramp done, restart
					thr_d = thr1_i;
				end else if (wrap) begin
					cnt_d = '0;
					thr_d = thr_q + step_ext;
				end else begin
					cnt_d = cnt_q + CNT_W'(1);
					pwm_d = (cnt_q < thr_q);
				end
			end

			// HOLD freezes everything
			default: ;
		endcase
	end

	always_ff @(posedge clk_i) begin
		if (!rst_i) begin
			cnt_q <= '0;
			thr_q <= '0;
			arm_q <= 1'b1;
			pwm_o <= 1'b0;
		end else begin
			cnt_q <= cnt_d;
			thr_q <= thr_d;
			arm_q <= arm_d;
			pwm_o <= pwm_d;
		end
	end

	a_idle_low: assert property (
		@(posedge clk_i) disable iff (!rst_i)
		(mode_i == MODE_OFF || mode_i == MODE_HOLD) |=> !pwm_o
	) else $error("pwm_o high after off/hold mode");

endmodule

`default_nettype wire

// File: verilog/pwm_pkg.sv
`default_nettype none

package pwm_pkg;

	// bus and datapath widths
	localparam int unsigned ADDR_W = 12;
	localparam int unsigned CNT_W  = 32;
	localparam int unsigned STEP_W = 12;
	localparam int unsigned MODE_W = 2;

	// each channel owns one 0x20 byte block
	localparam int unsigned CH_STRIDE = 'h20;

	// word offsets inside a channel block
	localparam logic [ADDR_W-1:0] REG_CTRL   = 'h00; // mode in bits 1:0
	localparam logic [ADDR_W-1:0] REG_PERIOD = 'h04;
	localparam logic [ADDR_W-1:0] REG_THR1   = 'h08;
	localparam logic [ADDR_W-1:0] REG_THR2   = 'h0C;
	localparam logic [ADDR_W-1:0] REG_STEP   = 'h10; // bits 11:0

	// channel mode codes
	localparam logic [MODE_W-1:0] MODE_OFF   = 2'd0; // output low, rearm
	localparam logic [MODE_W-1:0] MODE_STD   = 2'd1; // fixed duty
	localparam logic [MODE_W-1:0] MODE_HEART = 2'd2; // ramping duty
	localparam logic [MODE_W-1:0] MODE_HOLD  = 2'd3; // freeze, output low

endpackage

`default_nettype wire

// File: verilog/pwm_top.sv
`timescale 1ns/1ps
`default_nettype none

module pwm_top
	import pwm_pkg::*;
#(
	parameter int NUM_CH = 2
) (
	input  wire                clk_i,
	input  wire                rst_i,

	input  wire  [ADDR_W-1:0]  paddr_i,
	input  wire                psel_i,
	input  wire                penable_i,
	input  wire                pwrite_i,
	input  wire  [31:0]        pwdata_i,
	output logic [31:0]        prdata_o,
	output logic               pready_o,
	output logic               pslverr_o,

	output logic [NUM_CH-1:0]  pwm_o
);

	// per channel config, flattened by channel index
	logic [NUM_CH*MODE_W-1:0] mode_w;
	logic [NUM_CH*CNT_W-1:0]  period_w;
	logic [NUM_CH*CNT_W-1:0]  thr1_w;
	logic [NUM_CH*CNT_W-1:0]  thr2_w;
	logic [NUM_CH*STEP_W-1:0] step_w;

	pwm_apb_regs #(
		.NUM_CH    (NUM_CH)
	) u_regs (
		.clk_i     (clk_i),
		.rst_i     (rst_i),
		.paddr_i   (paddr_i),
		.psel_i    (psel_i),
		.penable_i (penable_i),
		.pwrite_i  (pwrite_i),
		.pwdata_i  (pwdata_i),
		.prdata_o  (prdata_o),
		.pready_o  (pready_o),
		.pslverr_o (pslverr_o),
		.mode_o    (mode_w),
		.period_o  (period_w),
		.thr1_o    (thr1_w),
		.thr2_o    (thr2_w),
		.step_o    (step_w)
	);

	for (genvar i = 0; i < NUM_CH; i++) begin : g_ch
		pwm_channel u_ch (
			.clk_i    (clk_i),
			.rst_i    (rst_i),
			.mode_i   (mode_w[i*MODE_W +: MODE_W]),
			.period_i (period_w[i*CNT_W +: CNT_W]),
			.thr1_i   (thr1_w[i*CNT_W +: CNT_W]),
			.thr2_i   (thr2_w[i*CNT_W +: CNT_W]),
			.step_i   (step_w[i*STEP_W +: STEP_W]),
			.pwm_o    (pwm_o[i])
		);
	end

endmodule

`default_nettype wire
